// ==== files.f ====
source/sram_loop_pkg.sv
source/uart_rx.sv
source/sram_spi_ctrl.sv
source/loop_seq.sv
source/sram_loop_top.sv
tb/sram_model.sv
tb/tb_sram_loop.sv

// ==== Makefile ====
# Verilator flow for the UART to serial SRAM loopback

VERILATOR ?= verilator
TOP       ?= tb_sram_loop
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_sram_loop.sv ====
// Directed testbench that drives UART frames into the SRAM loopback and checks LEDs and SRAM model
`timescale 1ns/100ps

module tb_sram_loop;

	localparam int CLK_FREQ  = 250_000_000;
	localparam int BAUD_RATE = 25_000_000;
	localparam int SCK_FREQ  = 62_500_000;
	localparam int BIT_CYC   = CLK_FREQ / BAUD_RATE;
	localparam int TIMEOUT   = 2000;
	localparam int AW        = sram_loop_pkg::SRAM_AW;

	logic          sysclk = 1'b0;
	logic          rst_n = 1'b0;
	logic          uart_rx = 1'b1;
	logic          sram_cs_n;
	logic          sram_sck;
	logic          sram_si;
	logic          sram_so;
	logic [7:0]    led;
	logic [31:0]   lfsr = 32'h2836;
	logic [AW-1:0] addr_exp = '0;
	int            err_cnt = 0;
	int            fail_cnt = 0;

	// 250 MHz
	always #2 sysclk = ~sysclk;

	sram_loop_top #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE),
		.SCK_FREQ  (SCK_FREQ)
	) u_sram_loop_top (
		.sysclk      (sysclk),
		.rst_n_i     (rst_n),
		.uart_rx_i   (uart_rx),
		.sram_so_i   (sram_so),
		.sram_cs_n_o (sram_cs_n),
		.sram_sck_o  (sram_sck),
		.sram_si_o   (sram_si),
		.led_o       (led)
	);

	sram_model u_sram_model (
		.cs_n_i (sram_cs_n),
		.sck_i  (sram_sck),
		.si_i   (sram_si),
		.so_o   (sram_so)
	);

	// Right-shifting Galois LFSR with taps 32, 31, 29 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'hD000_0001 : 32'h0);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [AW-1:0] got,
		input logic [AW-1:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s got %05h expected %05h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			err_cnt++;
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic apply_reset();
		@(posedge sysclk);
		rst_n <= 1'b0;
		repeat (2) @(posedge sysclk);
		rst_n <= 1'b1;
	endtask

	// 8N1 frame LSB first and then one idle bit
	task automatic send_byte(input logic [7:0] b, input logic bad_stop);
		logic [9:0] frame;
		frame = {~bad_stop, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			repeat (BIT_CYC) begin
				@(posedge sysclk);
				uart_rx <= frame[i];
			end
		end
		repeat (BIT_CYC) begin
			@(posedge sysclk);
			uart_rx <= 1'b1;
		end
	endtask

	// Completed model accesses of one kind
	function automatic int access_count(input logic is_read);
		return is_read ? u_sram_model.rd_count : u_sram_model.wr_count;
	endfunction

	// Polls the model on falling edges until an access count is reached
	task automatic wait_access(input string what, input logic is_read, input int target);
		int n;
		n = 0;
		while (access_count(is_read) < target && n < TIMEOUT) begin
			@(negedge sysclk);
			n++;
		end
		if (access_count(is_read) < target) begin
			fail_cnt++;
			$display("Timeout at %0t: %s %0d not seen in %0d cycles",
				$time, what, target, TIMEOUT);
		end
	endtask

	task automatic expect_no_spi(input int cycles);
		logic seen;
		seen = 1'b0;
		repeat (cycles) begin
			@(negedge sysclk);
			if (!sram_cs_n)
				seen = 1'b1;
		end
		if (seen) begin
			fail_cnt++;
			$display("Unexpected SPI transaction before %0t", $time);
		end
	endtask

	// Write then read of the expected cell and the LED shows the byte
	task automatic round_trip(input logic [7:0] b);
		int rd_before;
		int wr_before;
		rd_before = u_sram_model.rd_count;
		wr_before = u_sram_model.wr_count;
		send_byte(b, 1'b0);
		wait_access("write", 1'b0, wr_before + 1);
		// No read may complete ahead of the write
		check_count("sram reads at write end", u_sram_model.rd_count, rd_before);
		wait_access("read-back", 1'b1, rd_before + 1);
		// LED loads one cycle after the read's CS_n rise
		@(negedge sysclk);
		check_byte("led_o", led, b);
		check_byte("sram cell", u_sram_model.mem[addr_exp], b);
		check_count("sram writes", u_sram_model.wr_count, wr_before + 1);
		check_count("sram reads", u_sram_model.rd_count, rd_before + 1);
		check_addr("sram write addr", u_sram_model.last_wr_addr, addr_exp);
		check_addr("sram read addr", u_sram_model.last_rd_addr, addr_exp);
		addr_exp = addr_exp + 1'b1;
	endtask

	task automatic expect_idle_after_reset();
		@(negedge sysclk);
		check_byte("led_o", led, 8'h00);
		check_flag("sram_cs_n_o", sram_cs_n, 1'b1);
		check_flag("sram_sck_o", sram_sck, 1'b0);
		expect_no_spi(200);
		check_count("sram accesses", u_sram_model.wr_count + u_sram_model.rd_count, 0);
	endtask

	task automatic loop_random_bytes();
		logic [7:0] b;
		for (int k = 0; k < 16; k++) begin
			rand_byte(b);
			round_trip(b);
		end
		check_count("sram protocol errors", u_sram_model.proto_errs, 0);
	endtask

	// Framing error leaves LED and address untouched
	task automatic drop_bad_stop_frame();
		logic [7:0] led_before;
		int         acc_before;
		led_before = led;
		acc_before = u_sram_model.wr_count + u_sram_model.rd_count;
		send_byte(8'h3C, 1'b1);
		expect_no_spi(20 * BIT_CYC);
		check_byte("led_o", led, led_before);
		check_count("sram accesses", u_sram_model.wr_count + u_sram_model.rd_count, acc_before);
		round_trip(8'hC3);
	endtask

	task automatic restart_after_reset();
		apply_reset();
		@(negedge sysclk);
		check_byte("led_o", led, 8'h00);
		check_flag("sram_cs_n_o", sram_cs_n, 1'b1);
		check_flag("sram_sck_o", sram_sck, 1'b0);
		addr_exp = '0;
		round_trip(8'h5A);
	endtask

	initial begin
		apply_reset();
		expect_idle_after_reset();
		round_trip(8'hA5);
		loop_random_bytes();
		drop_bad_stop_frame();
		restart_after_reset();
		check_count("sram protocol errors", u_sram_model.proto_errs, 0);
		$display("Summary: %0d value errors, %0d other failures, %0d SRAM protocol errors",
			err_cnt, fail_cnt, u_sram_model.proto_errs);
		if (err_cnt == 0 && fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== tb/sram_model.sv ====
// Behavioral 23LC1024 byte-mode SPI SRAM for simulation that counts accesses and protocol errors
`timescale 1ns/100ps

module sram_model (
	input  logic cs_n_i,
	input  logic sck_i,
	input  logic si_i,
	output logic so_o
);

	localparam int AW = sram_loop_pkg::SRAM_AW;

	logic [7:0]    mem [0:(1 << AW) - 1];
	logic [39:0]   sr_q = '0;
	logic [5:0]    cnt_q = '0;
	logic [7:0]    cmd_q = '0;
	logic [23:0]   addr_q = '0;
	logic          so_q = 1'b0;
	logic [AW-1:0] last_wr_addr = '0;
	logic [AW-1:0] last_rd_addr = '0;
	int            wr_count = 0;
	int            rd_count = 0;
	int            proto_errs = 0;

	// Rising SCK shifts SI in and rising CS_n closes the frame
	always @(posedge sck_i or posedge cs_n_i) begin
		if (cs_n_i && sck_i) begin
			// Clock on a deselected part
			proto_errs <= proto_errs + 1;
		end else if (cs_n_i) begin
			// A select with no clocks at all is harmless
			if (cnt_q != 6'd40 && cnt_q != 6'd0) begin
				proto_errs <= proto_errs + 1;
			end else if (cnt_q == 6'd40 && cmd_q == sram_loop_pkg::CMD_WRITE) begin
				mem[addr_q[AW-1:0]] <= sr_q[7:0];
				last_wr_addr        <= addr_q[AW-1:0];
				wr_count            <= wr_count + 1;
			end else if (cnt_q == 6'd40 && cmd_q == sram_loop_pkg::CMD_READ) begin
				last_rd_addr <= addr_q[AW-1:0];
				rd_count     <= rd_count + 1;
			end
			cnt_q <= '0;
		end else begin
			sr_q <= {sr_q[38:0], si_i};
			if (cnt_q != 6'd63)
				cnt_q <= cnt_q + 6'd1;
			// Instruction complete after 8 bits
			if (cnt_q == 6'd7) begin
				cmd_q <= {sr_q[6:0], si_i};
				if ({sr_q[6:0], si_i} != sram_loop_pkg::CMD_WRITE &&
					{sr_q[6:0], si_i} != sram_loop_pkg::CMD_READ)
					proto_errs <= proto_errs + 1;
			end
			// 24-bit address with the top 7 bits zero
			if (cnt_q == 6'd31) begin
				addr_q <= {sr_q[22:0], si_i};
				if (sr_q[22:16] != 7'd0)
					proto_errs <= proto_errs + 1;
			end
		end
	end

	// Read data out on falling SCK with MSB first
	always @(negedge sck_i) begin
		if (!cs_n_i && cmd_q == sram_loop_pkg::CMD_READ && cnt_q >= 6'd32 && cnt_q < 6'd40)
			so_q <= mem[addr_q[AW-1:0]][3'(6'd39 - cnt_q)];
		else
			so_q <= 1'b0;
	end

	assign so_o = so_q;

endmodule

// ==== source/sram_loop_top.sv ====
// Top level of the UART to serial SRAM loopback, wires receiver, sequencer and SPI engine
`timescale 1ns/100ps

module sram_loop_top #(
	parameter int CLK_FREQ  = 12_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int SCK_FREQ  = 1_000_000
) (
	input  logic       sysclk,
	input  logic       rst_n_i,
	input  logic       uart_rx_i,
	input  logic       sram_so_i,
	output logic       sram_cs_n_o,
	output logic       sram_sck_o,
	output logic       sram_si_o,
	output logic [7:0] led_o
);

	// Receiver to sequencer
	logic [7:0]               rx_data;
	logic                     rx_valid;

	// Sequencer to SPI engine and back
	logic                     req_valid;
	sram_loop_pkg::sram_req_t req;
	logic                     done;
	logic [7:0]               rdata;

	uart_rx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_uart_rx (
		.sysclk     (sysclk),
		.rst_n_i    (rst_n_i),
		.rx_i       (uart_rx_i),
		.rx_data_o  (rx_data),
		.rx_valid_o (rx_valid)
	);

	loop_seq u_loop_seq (
		.sysclk      (sysclk),
		.rst_n_i     (rst_n_i),
		.rx_valid_i  (rx_valid),
		.rx_data_i   (rx_data),
		.done_i      (done),
		.rdata_i     (rdata),
		.req_valid_o (req_valid),
		.req_o       (req),
		.led_o       (led_o)
	);

	// SRAM side, byte mode over plain SPI
	sram_spi_ctrl #(
		.CLK_FREQ (CLK_FREQ),
		.SCK_FREQ (SCK_FREQ)
	) u_sram_spi_ctrl (
		.sysclk      (sysclk),
		.rst_n_i     (rst_n_i),
		.req_valid_i (req_valid),
		.req_i       (req),
		.done_o      (done),
		.rdata_o     (rdata),
		.sram_cs_n_o (sram_cs_n_o),
		.sram_sck_o  (sram_sck_o),
		.sram_si_o   (sram_si_o),
		.sram_so_i   (sram_so_i)
	);

endmodule

// ==== source/loop_seq.sv ====
// Sequencer turning each received byte into an SRAM write and read-back, drives the LEDs
`timescale 1ns/100ps

module loop_seq (
	input  logic                    sysclk,
	input  logic                    rst_n_i,
	input  logic                    rx_valid_i,
	input  logic [7:0]              rx_data_i,
	input  logic                    done_i,
	input  logic [7:0]              rdata_i,
	output logic                    req_valid_o,
	output sram_loop_pkg::sram_req_t req_o,
	output logic [7:0]              led_o
);

	sram_loop_pkg::seq_state_e          state_q;
	logic [sram_loop_pkg::SRAM_AW-1:0] addr_q;
	logic [7:0]                         byte_q;
	logic [7:0]                         led_q;
	logic                               req_valid_q;

	always_ff @(posedge sysclk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= sram_loop_pkg::SEQ_IDLE;
			addr_q      <= '0;
			led_q       <= '0;
			req_valid_q <= 1'b0;
		end else begin
			req_valid_q <= 1'b0;
			case (state_q)
				sram_loop_pkg::SEQ_IDLE: begin
					// Bytes arriving while busy are dropped
					if (rx_valid_i) begin
						req_valid_q <= 1'b1;
						state_q     <= sram_loop_pkg::SEQ_WAIT_WRITE;
					end
				end
				sram_loop_pkg::SEQ_WAIT_WRITE: begin
					// Read back the same cell
					if (done_i) begin
						req_valid_q <= 1'b1;
						state_q     <= sram_loop_pkg::SEQ_WAIT_READ;
					end
				end
				sram_loop_pkg::SEQ_WAIT_READ: begin
					// Show read byte, next cell, wraps at 128 KiB
					if (done_i) begin
						led_q   <= rdata_i;
						addr_q  <= addr_q + 1'b1;
						state_q <= sram_loop_pkg::SEQ_IDLE;
					end
				end
				default: state_q <= sram_loop_pkg::SEQ_IDLE;
			endcase
		end
	end

	// Byte register, payload only
	always_ff @(posedge sysclk) begin
		if (state_q == sram_loop_pkg::SEQ_IDLE && rx_valid_i)
			byte_q <= rx_data_i;
	end

	// Op follows the wait state entered with the strobe
	assign req_o.op    = (state_q == sram_loop_pkg::SEQ_WAIT_READ) ? sram_loop_pkg::OP_READ :
		sram_loop_pkg::OP_WRITE;
	assign req_o.addr  = addr_q;
	assign req_o.wdata = byte_q;
	assign req_valid_o = req_valid_q;
	assign led_o       = led_q;

	// Completion only for an outstanding request
	a_done_busy: assert property (@(posedge sysclk) disable iff (!rst_n_i)
		done_i |-> state_q != sram_loop_pkg::SEQ_IDLE)
		else $error("loop_seq: done_i while idle");

endmodule

// ==== source/sram_spi_ctrl.sv ====
// SPI mode 0 byte read and write engine for a 23LC1024 serial SRAM, one request per strobe
`timescale 1ns/100ps

module sram_spi_ctrl #(
	parameter int CLK_FREQ = 12_000_000,
	parameter int SCK_FREQ = 1_000_000
) (
	input  logic                    sysclk,
	input  logic                    rst_n_i,
	input  logic                    req_valid_i,
	input  sram_loop_pkg::sram_req_t req_i,
	output logic                    done_o,
	output logic [7:0]              rdata_o,
	output logic                    sram_cs_n_o,
	output logic                    sram_sck_o,
	output logic                    sram_si_o,
	input  logic                    sram_so_i
);

	// SCK half period in sysclk cycles, ratio must be even
	localparam int DIV  = CLK_FREQ / SCK_FREQ;
	localparam int HALF = DIV / 2;
	localparam int HW   = (HALF > 1) ? $clog2(HALF) : 1;

	// Last bit index of each frame field
	localparam logic [5:0] CMD_LAST  = 6'd7;
	localparam logic [5:0] ADDR_LAST = 6'd31;
	localparam logic [5:0] DATA_LAST = 6'd39;

	sram_loop_pkg::spi_state_e state_q;
	sram_loop_pkg::sram_cmd_e  cmd;
	logic [HW-1:0]             hcnt_q;
	logic                      tick;
	logic                      shifting;
	logic                      cs_n_q;
	logic                      sck_q;
	logic                      done_q;
	logic [5:0]                bit_q;
	logic [39:0]               tx_q;
	logic [7:0]                rx_q;

	// Instruction from request kind
	assign cmd = (req_i.op == sram_loop_pkg::OP_READ) ? sram_loop_pkg::CMD_READ :
		sram_loop_pkg::CMD_WRITE;

	assign shifting = (state_q == sram_loop_pkg::SPI_SHIFT_CMD) ||
		(state_q == sram_loop_pkg::SPI_SHIFT_ADDR) ||
		(state_q == sram_loop_pkg::SPI_SHIFT_DATA);

	// Half period timer, parked at zero while idle
	assign tick = (hcnt_q == HW'(HALF - 1));

	always_ff @(posedge sysclk or negedge rst_n_i) begin
		if (!rst_n_i)
			hcnt_q <= '0;
		else if (state_q == sram_loop_pkg::SPI_IDLE || tick)
			hcnt_q <= '0;
		else
			hcnt_q <= hcnt_q + 1'b1;
	end

	always_ff @(posedge sysclk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= sram_loop_pkg::SPI_IDLE;
			cs_n_q  <= 1'b1;
			sck_q   <= 1'b0;
			bit_q   <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				sram_loop_pkg::SPI_IDLE: begin
					// Select the chip the cycle after the request
					if (req_valid_i) begin
						cs_n_q  <= 1'b0;
						sck_q   <= 1'b0;
						bit_q   <= '0;
						state_q <= sram_loop_pkg::SPI_SHIFT_CMD;
					end
				end
				sram_loop_pkg::SPI_SHIFT_CMD,
				sram_loop_pkg::SPI_SHIFT_ADDR,
				sram_loop_pkg::SPI_SHIFT_DATA: begin
					if (tick) begin
						sck_q <= ~sck_q;
						// Falling edge ends one bit
						if (sck_q) begin
							bit_q <= bit_q + 6'd1;
							case (bit_q)
								CMD_LAST:  state_q <= sram_loop_pkg::SPI_SHIFT_ADDR;
								ADDR_LAST: state_q <= sram_loop_pkg::SPI_SHIFT_DATA;
								DATA_LAST: state_q <= sram_loop_pkg::SPI_FINISH;
								default:   state_q <= state_q;
							endcase
						end
					end
				end
				sram_loop_pkg::SPI_FINISH: begin
					// Half period of hold, then deselect and report
					if (tick) begin
						cs_n_q  <= 1'b1;
						done_q  <= 1'b1;
						state_q <= sram_loop_pkg::SPI_IDLE;
					end
				end
				default: state_q <= sram_loop_pkg::SPI_IDLE;
			endcase
		end
	end

	// Frame is cmd, 24-bit address, data byte, MSB first
	always_ff @(posedge sysclk) begin
		if (state_q == sram_loop_pkg::SPI_IDLE && req_valid_i)
			tx_q <= {cmd, {(24 - sram_loop_pkg::SRAM_AW){1'b0}}, req_i.addr, req_i.wdata};
		else if (shifting && tick && sck_q)
			tx_q <= {tx_q[38:0], 1'b0};
	end

	// SO captured on rising edges of the data byte; ignored for writes
	always_ff @(posedge sysclk) begin
		if (state_q == sram_loop_pkg::SPI_SHIFT_DATA && tick && !sck_q)
			rx_q <= {rx_q[6:0], sram_so_i};
	end

	assign sram_cs_n_o = cs_n_q;
	assign sram_sck_o  = sck_q;
	// SI held low while deselected
	assign sram_si_o   = tx_q[39] & ~cs_n_q;
	assign done_o      = done_q;
	assign rdata_o     = rx_q;

	// Sequencer may only request while the engine is free
	a_req_idle: assert property (@(posedge sysclk) disable iff (!rst_n_i)
		req_valid_i |-> state_q == sram_loop_pkg::SPI_IDLE)
		else $error("sram_spi_ctrl: request while busy");

	// Mode 0, no clock while deselected
	a_sck_cs: assert property (@(posedge sysclk) disable iff (!rst_n_i)
		sram_cs_n_o |-> !sram_sck_o)
		else $error("sram_spi_ctrl: SCK high with CS_n high");

endmodule

// ==== source/uart_rx.sv ====
// UART 8N1 receiver sampling each bit at its middle, one strobe per frame with a good stop bit
`timescale 1ns/100ps

module uart_rx #(
	parameter int CLK_FREQ  = 12_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  logic       sysclk,
	input  logic       rst_n_i,
	input  logic       rx_i,
	output logic [7:0] rx_data_o,
	output logic       rx_valid_o
);

	// Cycles per bit, and from start edge to bit middle
	localparam int BIT_CYC  = CLK_FREQ / BAUD_RATE;
	localparam int HALF_CYC = BIT_CYC / 2;
	localparam int CW       = $clog2(BIT_CYC + 1);

	// Local receive phases
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e     state_q;
	logic [1:0]    sync_q;
	logic          rx_dly_q;
	logic          rx_s;
	logic          start_fall;
	logic [CW-1:0] cnt_q;
	logic [2:0]    bit_q;
	logic [7:0]    shift_q;
	logic          valid_q;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge sysclk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_q   <= 2'b11;
			rx_dly_q <= 1'b1;
		end else begin
			sync_q   <= {sync_q[0], rx_i};
			rx_dly_q <= sync_q[1];
		end
	end

	assign rx_s       = sync_q[1];
	assign start_fall = rx_dly_q & ~rx_s;

	always_ff @(posedge sysclk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= RX_IDLE;
			cnt_q   <= '0;
			bit_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state_q)
				RX_IDLE: begin
					// Wait half a bit to land in the start bit middle
					if (start_fall) begin
						cnt_q   <= CW'(HALF_CYC - 1);
						state_q <= RX_START;
					end
				end
				RX_START: begin
					if (cnt_q == '0) begin
						// Glitch shorter than half a bit is dropped
						if (!rx_s) begin
							cnt_q   <= CW'(BIT_CYC - 1);
							bit_q   <= '0;
							state_q <= RX_DATA;
						end else begin
							state_q <= RX_IDLE;
						end
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				RX_DATA: begin
					if (cnt_q == '0) begin
						cnt_q <= CW'(BIT_CYC - 1);
						bit_q <= bit_q + 3'd1;
						if (bit_q == 3'd7)
							state_q <= RX_STOP;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				RX_STOP: begin
					// Framing error discards the byte silently
					if (cnt_q == '0) begin
						valid_q <= rx_s;
						state_q <= RX_IDLE;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first, shifts down from the top
	always_ff @(posedge sysclk) begin
		if (state_q == RX_DATA && cnt_q == '0)
			shift_q <= {rx_s, shift_q[7:1]};
	end

	assign rx_data_o  = shift_q;
	assign rx_valid_o = valid_q;

	// Strobe must be a single cycle for the sequencer
	a_valid_pulse: assert property (@(posedge sysclk) disable iff (!rst_n_i)
		rx_valid_o |=> !rx_valid_o)
		else $error("uart_rx: rx_valid_o held for more than one cycle");

endmodule

// ==== source/sram_loop_pkg.sv ====
// Shared types for the UART to serial SRAM loopback, referenced by scoped name
package sram_loop_pkg;

	// 23LC1024 array is 128 KiB
	parameter int SRAM_AW = 17;

	// Request kind from sequencer to SPI engine
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} sram_op_e;

	// SPI instruction bytes, byte mode only
	typedef enum logic [7:0] {
		CMD_WRITE = 8'h02,
		CMD_READ  = 8'h03
	} sram_cmd_e;

	// One SRAM access, 26 bits
	typedef struct packed {
		sram_op_e           op;
		logic [SRAM_AW-1:0] addr;
		logic [7:0]         wdata;
	} sram_req_t;

	// Sequencer FSM
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WAIT_WRITE,
		SEQ_WAIT_READ
	} seq_state_e;

	// SPI engine FSM, one phase per frame field
	typedef enum logic [2:0] {
		SPI_IDLE,
		SPI_SHIFT_CMD,
		SPI_SHIFT_ADDR,
		SPI_SHIFT_DATA,
		SPI_FINISH
	} spi_state_e;

endpackage
